// ==== hw/ram_pm_pkg.sv ====
`default_nettype none

package ram_pm_pkg;

    // Write width, encodings follow the processor's load/store unit
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2   // 2'd3 is unused and rejected as misaligned
    } access_size_t;

    // Storage element
    localparam int BYTE_W = 8;

    // Lane counts on the data buses
    localparam int WORD_BYTES  = 4;
    localparam int DWORD_BYTES = 8;

    localparam int WORD_W  = WORD_BYTES * BYTE_W;   // Upper half of the read bus starts here
    localparam int DWORD_W = DWORD_BYTES * BYTE_W;

    // Low address bits that must be zero for an aligned access
    localparam int WORD_OFS_BITS  = $clog2(WORD_BYTES);
    localparam int DWORD_OFS_BITS = $clog2(DWORD_BYTES);

    // Peripheral configuration bytes at the bottom of the address space
    localparam int RESERVED_COUNT = 4;

    // Reset values, index 0 is address 0
    //   0x00  port A
    //   0x01  port B
    //   0x02  UART RX config
    //   0x03  UART TX config
    localparam logic [RESERVED_COUNT-1:0][BYTE_W-1:0] RESERVED_DEFAULT = {
        8'h8F,
        8'h23,
        8'h00,
        8'h00
    };

endpackage

`default_nettype wire

// ==== hw/ram_pm_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One checked write command, write controller to storage array
interface ram_pm_wr_if #(
    parameter int ADDR_DEPTH = 256
);

    localparam int AW = $clog2(ADDR_DEPTH);

    logic                              wr_en;  // Single-cycle strobe per aligned write
    logic [AW-1:0]                     addr;
    ram_pm_pkg::access_size_t          size;
    logic [ram_pm_pkg::DWORD_W-1:0]    data;   // Little endian, byte 0 in [7:0]

    modport ctrl (
        output wr_en,
        output addr,
        output size,
        output data
    );

    modport array (
        input wr_en,
        input addr,
        input size,
        input data
    );

endinterface

`default_nettype wire

// ==== hw/ram_pm_wr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_pm_wr_ctrl #(
    parameter int ADDR_DEPTH = 256
) (
    input  wire                                clk,
    input  wire                                rst_n,

    // Request channel
    input  wire                                wr_valid_i,
    output logic                               wr_ready_o,
    input  wire [$clog2(ADDR_DEPTH)-1:0]       wr_addr_i,
    input  wire ram_pm_pkg::access_size_t      wr_size_i,
    input  wire [ram_pm_pkg::DWORD_W-1:0]      wr_data_i,

    // Response channel
    output logic                               wr_resp_valid_o,
    input  wire                                wr_resp_ready_i,
    output logic                               wr_err_o,

    ram_pm_wr_if.ctrl                          cmd
);

    localparam int AW = $clog2(ADDR_DEPTH);

    logic                           accept;
    logic                           misaligned;

    logic                           wr_en_q;
    logic [AW-1:0]                  addr_q;
    ram_pm_pkg::access_size_t       size_q;
    logic [ram_pm_pkg::DWORD_W-1:0] data_q;

    logic                           pend_q;        // Accepted, response not yet built
    logic                           pend_err_q;
    logic                           resp_valid_q;
    logic                           resp_err_q;

    // Free slot, or the held response leaves this cycle
    assign wr_ready_o = !resp_valid_q || wr_resp_ready_i;
    assign accept     = wr_valid_i && wr_ready_o;

    always_comb begin
        case (wr_size_i)
            ram_pm_pkg::SIZE_BYTE:  misaligned = 1'b0;
            ram_pm_pkg::SIZE_WORD:  misaligned = |wr_addr_i[ram_pm_pkg::WORD_OFS_BITS-1:0];
            ram_pm_pkg::SIZE_DWORD: misaligned = |wr_addr_i[ram_pm_pkg::DWORD_OFS_BITS-1:0];
            default:                misaligned = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_q      <= 1'b0;
            pend_q       <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            wr_en_q <= accept && !misaligned;  // Storage updates one edge later
            if (wr_ready_o) begin
                resp_valid_q <= pend_q;
            end
            if (accept) begin
                pend_q <= 1'b1;
            end else if (wr_ready_o) begin
                pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= wr_addr_i;
            size_q     <= wr_size_i;
            data_q     <= wr_data_i;
            pend_err_q <= misaligned;
        end
        if (wr_ready_o && pend_q) begin
            resp_err_q <= pend_err_q;
        end
    end

    assign cmd.wr_en = wr_en_q;
    assign cmd.addr  = addr_q;
    assign cmd.size  = size_q;
    assign cmd.data  = data_q;

    assign wr_resp_valid_o = resp_valid_q;
    assign wr_err_o        = resp_err_q;

endmodule

`default_nettype wire

// ==== hw/ram_pm_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_pm_rd_ctrl #(
    parameter int ADDR_DEPTH = 256
) (
    input  wire                             clk,
    input  wire                             rst_n,

    // Request channel
    input  wire                             rd_valid_i,
    output logic                            rd_ready_o,
    input  wire [$clog2(ADDR_DEPTH)-1:0]    rd_addr_i,

    // Response channel
    input  wire                             rd_resp_ready_i,
    output logic                            rd_resp_valid_o,
    output logic [ram_pm_pkg::DWORD_W-1:0]  rd_data_o,
    output logic                            rd_invalid_o,
    output logic                            rd_overflow_o,

    // Array side
    output logic [$clog2(ADDR_DEPTH)-1:0]   rd_addr_o,
    input  wire [ram_pm_pkg::DWORD_W-1:0]   rd_dword_i
);

    localparam int AW = $clog2(ADDR_DEPTH);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,   // Address buffered, array output settles
        RD_HOLD     // Response on the bus
    } rd_state_t;

    rd_state_t                      state_q;
    logic                           accept;
    logic [AW-1:0]                  addr_q;
    logic [ram_pm_pkg::DWORD_W-1:0] data_q;
    logic                           invalid_q;
    logic                           overflow_q;

    // No new address while a fetch is in flight, so the snapshot edge stays fixed
    assign rd_ready_o = (state_q == RD_IDLE) || (state_q == RD_HOLD && rd_resp_ready_i);
    assign accept     = rd_valid_i && rd_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= RD_IDLE;
        end else begin
            case (state_q)
                RD_IDLE:  if (accept) state_q <= RD_FETCH;
                RD_FETCH: state_q <= RD_HOLD;
                RD_HOLD: begin
                    if (rd_resp_ready_i) begin
                        state_q <= accept ? RD_FETCH : RD_IDLE;  // Back-to-back reads
                    end
                end
                default:  state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= rd_addr_i;
        end
        if (state_q == RD_FETCH) begin
            data_q     <= rd_dword_i;
            invalid_q  <= |addr_q[ram_pm_pkg::WORD_OFS_BITS-1:0];
            overflow_q <= (addr_q == AW'(ADDR_DEPTH - ram_pm_pkg::WORD_BYTES));
        end
    end

    assign rd_addr_o       = addr_q;
    assign rd_resp_valid_o = (state_q == RD_HOLD);
    assign rd_data_o       = data_q;
    assign rd_invalid_o    = invalid_q;
    assign rd_overflow_o   = overflow_q;

endmodule

`default_nettype wire

// ==== hw/ram_pm_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_pm_array #(
    parameter int ADDR_DEPTH = 256
) (
    input  wire                                clk,
    input  wire                                rst_n,

    ram_pm_wr_if.array                         cmd,

    input  wire [$clog2(ADDR_DEPTH)-1:0]       rd_addr_i,
    output logic [ram_pm_pkg::DWORD_W-1:0]     rd_dword_o,

    output logic [ram_pm_pkg::RESERVED_COUNT-1:0][ram_pm_pkg::BYTE_W-1:0] cfg_o
);

    localparam int AW        = $clog2(ADDR_DEPTH);
    localparam int BW        = ram_pm_pkg::BYTE_W;
    localparam int WORD_OFS  = ram_pm_pkg::WORD_OFS_BITS;
    localparam int DWORD_OFS = ram_pm_pkg::DWORD_OFS_BITS;
    localparam int LAST_WORD = ADDR_DEPTH / ram_pm_pkg::WORD_BYTES - 1;

    logic [BW-1:0]          mem [ADDR_DEPTH];
    logic [AW-WORD_OFS-1:0] rd_word_idx;
    logic [AW-1:0]          rd_base;

    for (genvar i = 0; i < ADDR_DEPTH; i++) begin : g_byte
        // Configuration bytes come up with their defaults
        localparam logic [BW-1:0] RST_VAL = (i < ram_pm_pkg::RESERVED_COUNT) ?
            ram_pm_pkg::RESERVED_DEFAULT[i % ram_pm_pkg::RESERVED_COUNT] : '0;
        localparam int WORD_LANE  = i % ram_pm_pkg::WORD_BYTES;
        localparam int DWORD_LANE = i % ram_pm_pkg::DWORD_BYTES;

        logic          hit;    // Byte lies inside the addressed block
        logic [BW-1:0] wdata;
        logic [BW-1:0] byte_q;

        always_comb begin
            case (cmd.size)
                ram_pm_pkg::SIZE_BYTE: begin
                    hit   = (cmd.addr == AW'(i));
                    wdata = cmd.data[BW-1:0];
                end
                ram_pm_pkg::SIZE_WORD: begin
                    hit   = (cmd.addr[AW-1:WORD_OFS] == (AW-WORD_OFS)'(i >> WORD_OFS));
                    wdata = cmd.data[WORD_LANE*BW +: BW];
                end
                ram_pm_pkg::SIZE_DWORD: begin
                    hit   = (cmd.addr[AW-1:DWORD_OFS] == (AW-DWORD_OFS)'(i >> DWORD_OFS));
                    wdata = cmd.data[DWORD_LANE*BW +: BW];
                end
                default: begin
                    hit   = 1'b0;
                    wdata = '0;
                end
            endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                byte_q <= RST_VAL;
            end else if (cmd.wr_en && hit) begin
                byte_q <= wdata;
            end
        end

        assign mem[i] = byte_q;
    end

    // Read side works on word granularity, low two bits ignored
    assign rd_word_idx = rd_addr_i[AW-1:WORD_OFS];
    assign rd_base     = {rd_word_idx, {WORD_OFS{1'b0}}};

    always_comb begin
        for (int k = 0; k < ram_pm_pkg::DWORD_BYTES; k++) begin
            rd_dword_o[k*BW +: BW] = mem[rd_base + AW'(k)];  // Wraps on the last word
        end
        if (rd_word_idx == (AW-WORD_OFS)'(LAST_WORD)) begin
            rd_dword_o[ram_pm_pkg::DWORD_W-1:ram_pm_pkg::WORD_W] = '0;  // Nothing above the top
        end
    end

    for (genvar r = 0; r < ram_pm_pkg::RESERVED_COUNT; r++) begin : g_cfg
        assign cfg_o[r] = mem[r];
    end

endmodule

`default_nettype wire

// ==== hw/ram_pm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_pm_top #(
    parameter int ADDR_DEPTH = 256   // Bytes, power of two, 16 or more
) (
    input  wire                                clk,
    input  wire                                rst_n,

    // Write request
    input  wire                                wr_valid_i,
    output wire                                wr_ready_o,
    input  wire [$clog2(ADDR_DEPTH)-1:0]       wr_addr_i,
    input  wire ram_pm_pkg::access_size_t      wr_size_i,
    input  wire [ram_pm_pkg::DWORD_W-1:0]      wr_data_i,

    // Write response
    output wire                                wr_resp_valid_o,
    input  wire                                wr_resp_ready_i,
    output wire                                wr_err_o,

    // Read request
    input  wire                                rd_valid_i,
    output wire                                rd_ready_o,
    input  wire [$clog2(ADDR_DEPTH)-1:0]       rd_addr_i,

    // Read response
    output wire                                rd_resp_valid_o,
    input  wire                                rd_resp_ready_i,
    output wire [ram_pm_pkg::DWORD_W-1:0]      rd_data_o,
    output wire                                rd_invalid_o,
    output wire                                rd_overflow_o,

    // Peripheral configuration
    output wire [ram_pm_pkg::RESERVED_COUNT-1:0][ram_pm_pkg::BYTE_W-1:0] cfg_o
);

    localparam int AW = $clog2(ADDR_DEPTH);

    wire [AW-1:0]                  rd_addr;
    wire [ram_pm_pkg::DWORD_W-1:0] rd_dword;

    ram_pm_wr_if #(.ADDR_DEPTH(ADDR_DEPTH)) wr_bus ();

    ram_pm_wr_ctrl #(.ADDR_DEPTH(ADDR_DEPTH)) u_wr_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_valid_i      (wr_valid_i),
        .wr_ready_o      (wr_ready_o),
        .wr_addr_i       (wr_addr_i),
        .wr_size_i       (wr_size_i),
        .wr_data_i       (wr_data_i),
        .wr_resp_valid_o (wr_resp_valid_o),
        .wr_resp_ready_i (wr_resp_ready_i),
        .wr_err_o        (wr_err_o),
        .cmd             (wr_bus.ctrl)
    );

    ram_pm_rd_ctrl #(.ADDR_DEPTH(ADDR_DEPTH)) u_rd_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_valid_i      (rd_valid_i),
        .rd_ready_o      (rd_ready_o),
        .rd_addr_i       (rd_addr_i),
        .rd_resp_ready_i (rd_resp_ready_i),
        .rd_resp_valid_o (rd_resp_valid_o),
        .rd_data_o       (rd_data_o),
        .rd_invalid_o    (rd_invalid_o),
        .rd_overflow_o   (rd_overflow_o),
        .rd_addr_o       (rd_addr),
        .rd_dword_i      (rd_dword)
    );

    ram_pm_array #(.ADDR_DEPTH(ADDR_DEPTH)) u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (wr_bus.array),
        .rd_addr_i  (rd_addr),
        .rd_dword_o (rd_dword),
        .cfg_o      (cfg_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // Free running
    end

endmodule

`default_nettype wire

// ==== bench/tb_ram_model.svh ====
`ifndef TB_RAM_MODEL_SVH
`define TB_RAM_MODEL_SVH

// Reference byte array, index is the byte address
logic [7:0] ref_mem [DEPTH];

function automatic void clear_ref_bytes();
    int a;
    for (a = 0; a < DEPTH; a++) begin
        ref_mem[a] = 8'h00;
    end
    for (a = 0; a < ram_pm_pkg::RESERVED_COUNT; a++) begin
        ref_mem[a] = ram_pm_pkg::RESERVED_DEFAULT[a];  // Peripheral defaults
    end
endfunction

// Returns the expected error bit; a rejected write leaves the bytes alone
function automatic logic apply_write(input int addr, input ram_pm_pkg::access_size_t size,
                                     input logic [63:0] data);
    int nbytes;
    int k;
    case (size)
        ram_pm_pkg::SIZE_BYTE:  nbytes = 1;
        ram_pm_pkg::SIZE_WORD:  nbytes = 4;
        ram_pm_pkg::SIZE_DWORD: nbytes = 8;
        default:                nbytes = 0;   // Undefined width
    endcase
    if (nbytes == 0 || addr % nbytes != 0) begin
        return 1'b1;
    end
    for (k = 0; k < nbytes; k++) begin
        ref_mem[addr + k] = data[8*k +: 8];  // Little endian
    end
    return 1'b0;
endfunction

function automatic logic [63:0] expected_dword(input int addr);
    int          base;
    int          k;
    logic [63:0] dword;
    base  = addr - addr % 4;  // Rounded down to a word
    dword = '0;
    for (k = 0; k < 8; k++) begin
        if (base + k < DEPTH) begin
            dword[8*k +: 8] = ref_mem[base + k];
        end
    end
    return dword;
endfunction

function automatic logic read_misaligned(input int addr);
    return addr % 4 != 0;
endfunction

function automatic logic read_overflows(input int addr);
    return addr == DEPTH - 4;
endfunction

function automatic logic [ram_pm_pkg::RESERVED_COUNT-1:0][7:0] config_bytes();
    logic [ram_pm_pkg::RESERVED_COUNT-1:0][7:0] cfg;
    int r;
    for (r = 0; r < ram_pm_pkg::RESERVED_COUNT; r++) begin
        cfg[r] = ref_mem[r];
    end
    return cfg;
endfunction

`endif

// ==== bench/tb_ram_pm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ram_pm;

    localparam int  DEPTH     = 256;
    localparam int  AW        = $clog2(DEPTH);
    localparam int  RC        = ram_pm_pkg::RESERVED_COUNT;
    localparam real CLK_NS    = 4.0;
    localparam int  SEED      = 32'h620467a7;
    localparam int  N_ALIGN   = 150;
    localparam int  N_MISAL   = 100;
    localparam int  N_FLAGS   = 80;
    localparam int  N_BACKP   = 150;
    localparam int  N_CONCUR  = 120;
    localparam int  TOTAL_TXN = 2 * (N_ALIGN + N_MISAL + N_FLAGS + N_BACKP + N_CONCUR);

    localparam int MODE_ALIGN  = 0;
    localparam int MODE_MISAL  = 1;
    localparam int MODE_FLAGS  = 2;
    localparam int MODE_BACKP  = 3;
    localparam int MODE_CONCUR = 4;

    wire                        clk;
    logic                       rst_n;
    logic                       wr_valid_i;
    wire                        wr_ready_o;
    logic [AW-1:0]              wr_addr_i;
    ram_pm_pkg::access_size_t   wr_size_i;
    logic [63:0]                wr_data_i;
    wire                        wr_resp_valid_o;
    logic                       wr_resp_ready_i;
    wire                        wr_err_o;
    logic                       rd_valid_i;
    wire                        rd_ready_o;
    logic [AW-1:0]              rd_addr_i;
    wire                        rd_resp_valid_o;
    logic                       rd_resp_ready_i;
    wire  [63:0]                rd_data_o;
    wire                        rd_invalid_o;
    wire                        rd_overflow_o;
    wire  [RC-1:0][7:0]         cfg_o;

    string              test_name;
    int                 errors;
    int                 wr_count;
    int                 rd_count;
    logic               wr_err_q [$];    // Expected responses in acceptance order
    logic [65:0]        rd_exp_q [$];    // {invalid, overflow, data}
    logic               wr_held;
    logic               wr_held_err;
    logic               rd_held;
    logic [65:0]        rd_held_resp;
    logic [RC-1:0][7:0] cfg_snap;        // Model bytes one write behind

    `include "tb_ram_model.svh"

    tb_clk_gen #(.PERIOD_NS(CLK_NS)) clk_gen (.clk_o(clk));

    ram_pm_top #(.ADDR_DEPTH(DEPTH)) UUT (
        .clk(clk), .rst_n(rst_n),
        .wr_valid_i(wr_valid_i), .wr_ready_o(wr_ready_o), .wr_addr_i(wr_addr_i),
        .wr_size_i(wr_size_i), .wr_data_i(wr_data_i),
        .wr_resp_valid_o(wr_resp_valid_o), .wr_resp_ready_i(wr_resp_ready_i),
        .wr_err_o(wr_err_o),
        .rd_valid_i(rd_valid_i), .rd_ready_o(rd_ready_o), .rd_addr_i(rd_addr_i),
        .rd_resp_valid_o(rd_resp_valid_o), .rd_resp_ready_i(rd_resp_ready_i),
        .rd_data_o(rd_data_o), .rd_invalid_o(rd_invalid_o), .rd_overflow_o(rd_overflow_o),
        .cfg_o(cfg_o)
    );

    task automatic report_mismatch(input string what, input logic [65:0] expected,
                                   input logic [65:0] actual);
        errors++;
        $display("Fail %s: %s expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("Error in %s: %s", test_name, what);
    endtask

    task automatic drive_write(input int mode);
        int sz;
        int addr;
        sz = (mode == MODE_MISAL) ? int'($urandom % 4) : int'($urandom % 3);
        case (mode)
            MODE_BACKP:  addr = int'($urandom % 16);   // Mostly the cfg bytes
            MODE_CONCUR: addr = int'($urandom % 32);
            default:     addr = int'($urandom % DEPTH);
        endcase
        if (mode != MODE_MISAL && sz > 0) begin
            addr = addr - addr % ((sz == 1) ? 4 : 8);
        end
        wr_valid_i = 1'b1;
        wr_addr_i  = AW'(addr);
        wr_size_i  = ram_pm_pkg::access_size_t'(2'(sz));
        wr_data_i  = {$urandom, $urandom};
    endtask

    task automatic drive_read(input int mode);
        int addr;
        case (mode)
            MODE_FLAGS:  addr = ($urandom % 4 == 0) ? DEPTH - 4 + int'($urandom % 4)
                                                    : int'($urandom % DEPTH);
            MODE_BACKP:  addr = int'($urandom % 16);
            MODE_CONCUR: addr = int'($urandom % 32);
            default:     addr = int'($urandom % DEPTH);
        endcase
        if (mode != MODE_FLAGS) begin
            addr = addr - addr % 4;
        end
        rd_valid_i = 1'b1;
        rd_addr_i  = AW'(addr);
    endtask

    // Runs just before a rising edge, after the inputs have settled
    task automatic sample_edge(output logic wr_fire, output logic rd_fire);
        logic [65:0] got_rd;
        logic [65:0] exp_rd;
        logic        exp_err;
        got_rd = {rd_invalid_o, rd_overflow_o, rd_data_o};
        if (cfg_o !== cfg_snap) report_mismatch("cfg_o", 66'(cfg_snap), 66'(cfg_o));
        if (wr_held && !wr_resp_valid_o) begin
            report_problem("write response dropped before it was taken");
        end else if (wr_held && wr_err_o !== wr_held_err) begin
            report_mismatch("held wr_err_o", 66'(wr_held_err), 66'(wr_err_o));
        end
        if (rd_held && !rd_resp_valid_o) begin
            report_problem("read response dropped before it was taken");
        end else if (rd_held && got_rd !== rd_held_resp) begin
            report_mismatch("held read response", rd_held_resp, got_rd);
        end
        if (wr_resp_valid_o && wr_resp_ready_i) begin
            wr_held = 1'b0;
            if (wr_err_q.size() == 0) begin
                report_problem("write response with no write outstanding");
            end else begin
                exp_err = wr_err_q.pop_front();
                wr_count++;
                if (wr_err_o !== exp_err) report_mismatch("wr_err_o", 66'(exp_err), 66'(wr_err_o));
            end
        end else if (wr_resp_valid_o && !wr_held) begin
            wr_held     = 1'b1;
            wr_held_err = wr_err_o;
        end else if (!wr_resp_valid_o) begin
            wr_held = 1'b0;
        end
        if (rd_resp_valid_o && rd_resp_ready_i) begin
            rd_held = 1'b0;
            if (rd_exp_q.size() == 0) begin
                report_problem("read response with no read outstanding");
            end else begin
                exp_rd = rd_exp_q.pop_front();
                rd_count++;
                if (rd_data_o !== exp_rd[63:0]) begin
                    report_mismatch("rd_data_o", 66'(exp_rd[63:0]), 66'(rd_data_o));
                end
                if (rd_invalid_o !== exp_rd[65]) begin
                    report_mismatch("rd_invalid_o", 66'(exp_rd[65]), 66'(rd_invalid_o));
                end
                if (rd_overflow_o !== exp_rd[64]) begin
                    report_mismatch("rd_overflow_o", 66'(exp_rd[64]), 66'(rd_overflow_o));
                end
            end
        end else if (rd_resp_valid_o && !rd_held) begin
            rd_held      = 1'b1;
            rd_held_resp = got_rd;
        end else if (!rd_resp_valid_o) begin
            rd_held = 1'b0;
        end
        wr_fire  = wr_valid_i && wr_ready_o;
        rd_fire  = rd_valid_i && rd_ready_o;
        cfg_snap = config_bytes();
        if (rd_fire) begin  // Read snapshot before a same-edge write
            rd_exp_q.push_back({read_misaligned(int'(rd_addr_i)), read_overflows(int'(rd_addr_i)),
                                expected_dword(int'(rd_addr_i))});
        end
        if (wr_fire) wr_err_q.push_back(apply_write(int'(wr_addr_i), wr_size_i, wr_data_i));
    endtask

    task automatic run_phase(input string name, input int n_ops, input int mode);
        int   wr_left;
        int   rd_left;
        logic wr_fire;
        logic rd_fire;
        test_name = name;
        wr_left   = n_ops;
        rd_left   = n_ops;
        wr_fire   = 1'b0;
        rd_fire   = 1'b0;
        while (wr_left > 0 || rd_left > 0 || wr_err_q.size() > 0 || rd_exp_q.size() > 0) begin
            @(negedge clk);
            if (wr_fire || !wr_valid_i) begin   // Request held until accepted
                wr_valid_i = 1'b0;
                if (wr_left > 0 && (mode == MODE_CONCUR || $urandom % 4 != 0)) drive_write(mode);
            end
            if (rd_fire || !rd_valid_i) begin
                rd_valid_i = 1'b0;
                if (rd_left > 0 && (mode == MODE_CONCUR || $urandom % 4 != 0)) drive_read(mode);
            end
            wr_resp_ready_i = (mode != MODE_BACKP) || ($urandom % 2 == 0);
            rd_resp_ready_i = (mode != MODE_BACKP) || ($urandom % 2 == 0);
            #1;
            sample_edge(wr_fire, rd_fire);
            if (wr_fire) wr_left--;
            if (rd_fire) rd_left--;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        errors          = 0;
        wr_count        = 0;
        rd_count        = 0;
        rst_n           = 1'b0;
        wr_valid_i      = 1'b0;
        wr_addr_i       = '0;
        wr_size_i       = ram_pm_pkg::SIZE_BYTE;
        wr_data_i       = '0;
        wr_resp_ready_i = 1'b0;   // Ready outputs then come from the empty response slots
        rd_valid_i      = 1'b0;
        rd_addr_i       = '0;
        rd_resp_ready_i = 1'b0;
        wr_held         = 1'b0;
        wr_held_err     = 1'b0;
        rd_held         = 1'b0;
        rd_held_resp    = '0;
        clear_ref_bytes();
        cfg_snap  = config_bytes();
        test_name = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        if (wr_ready_o !== 1'b1) report_mismatch("wr_ready_o", 66'(1'b1), 66'(wr_ready_o));
        if (rd_ready_o !== 1'b1) report_mismatch("rd_ready_o", 66'(1'b1), 66'(rd_ready_o));
        if (wr_resp_valid_o !== 1'b0) begin
            report_mismatch("wr_resp_valid_o", 66'(1'b0), 66'(wr_resp_valid_o));
        end
        if (rd_resp_valid_o !== 1'b0) begin
            report_mismatch("rd_resp_valid_o", 66'(1'b0), 66'(rd_resp_valid_o));
        end
        if (cfg_o !== ram_pm_pkg::RESERVED_DEFAULT) begin
            report_mismatch("cfg_o", 66'(ram_pm_pkg::RESERVED_DEFAULT), 66'(cfg_o));
        end
        run_phase("aligned", N_ALIGN, MODE_ALIGN);
        run_phase("misaligned", N_MISAL, MODE_MISAL);
        run_phase("read_flags", N_FLAGS, MODE_FLAGS);
        run_phase("backpressure", N_BACKP, MODE_BACKP);
        run_phase("concurrent", N_CONCUR, MODE_CONCUR);
        $display("Summary: %0d errors, %0d write and %0d read responses checked",
                 errors, wr_count, rd_count);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Generous budget per transaction
    initial begin
        #(TOTAL_TXN * 20 * CLK_NS);
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_TXN * 20);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+bench
hw/ram_pm_pkg.sv
hw/ram_pm_wr_if.sv
hw/ram_pm_wr_ctrl.sv
hw/ram_pm_rd_ctrl.sv
hw/ram_pm_array.sv
hw/ram_pm_top.sv
bench/tb_clk_gen.sv
bench/tb_ram_pm.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RAM testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f vlog.f --top-module tb_ram_pm -Mdir obj_dir

./obj_dir/Vtb_ram_pm > "$LOG" 2>&1
cat "$LOG"

if grep -q -F '*** FAILED ***' "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation finished without failures"
